/* Bender.yml */
package:
  name: sector_log

sources:
  - files:
      - rtl/sectorLogPkg.sv
      - rtl/uartByteRx.sv
      - rtl/byteFifo.sv
      - rtl/sectorWriter.sv
      - rtl/sectorLogTop.sv
  - target: test
    files:
      - testbench/tbSectorLog.sv

/* rtl/byteFifo.sv */
// first-word-fall-through byte FIFO with sticky overflow flag
`timescale 1ns/1ps
`default_nettype none

module byteFifo (
  input  logic       clk,
  input  logic       rstn,
  input  logic       push,
  input  logic [7:0] pushByte,
  input  logic       pop,
  output logic [7:0] headByte,
  output logic       notEmpty,
  output logic       overflow
);

  logic [7:0] mem [sectorLogPkg::fifoDepth];
  logic [sectorLogPkg::fifoPtrW-1:0] wrPtr;
  logic [sectorLogPkg::fifoPtrW-1:0] rdPtr;
  logic [sectorLogPkg::fifoCountW-1:0] count;
  logic full;
  logic doPush;
  logic doPop;

  assign full = (count == sectorLogPkg::fifoCountW'(sectorLogPkg::fifoDepth));
  assign notEmpty = (count != '0);
  // a byte arriving while full is simply lost
  assign doPush = push && !full;
  assign doPop = pop && notEmpty;

  // head is visible straight from storage
  assign headByte = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushByte;
    end
  end

  // ------------------------------
  // pointers and fill level
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPush) begin
        // explicit wrap, depth need not be a power of two
        wrPtr <= (wrPtr == sectorLogPkg::fifoPtrW'(sectorLogPkg::fifoDepth - 1)) ?
                 '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == sectorLogPkg::fifoPtrW'(sectorLogPkg::fifoDepth - 1)) ?
                 '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  // writer must only pop what is there
  popNotEmpty: assert property (@(posedge clk) disable iff (!rstn)
    pop |-> notEmpty);

  countInRange: assert property (@(posedge clk) disable iff (!rstn)
    count <= sectorLogPkg::fifoCountW'(sectorLogPkg::fifoDepth));

endmodule

`default_nettype wire

/* rtl/sectorLogPkg.sv */
// shared constants and APB request/response structs for the sector logger
`default_nettype none

package sectorLogPkg;

  // ------------------------------
  // uart framing
  // ------------------------------
  // clock cycles per serial bit
  localparam int bitCycles = 8;
  localparam int bitTickW = $clog2(bitCycles);

  // ------------------------------
  // sector geometry
  // ------------------------------
  localparam int sectorBytes = 512;
  localparam int wordBytes = 4;
  localparam int wordsPerSector = sectorBytes / wordBytes;
  localparam int wordIdxW = $clog2(wordsPerSector);
  // data sectors between two length records
  localparam int updateEvery = 2;
  // file length limit, writer stops after this many sectors
  localparam int maxSectors = 16;
  localparam int sectorCntW = $clog2(maxSectors + 1);

  // byte addresses in the block store
  localparam logic [31:0] dataBase = 32'h0000_1000;
  localparam logic [31:0] lengthAddr = 32'h0000_0040;

  // ------------------------------
  // byte fifo
  // ------------------------------
  localparam int fifoDepth = 16;
  localparam int fifoPtrW = $clog2(fifoDepth);
  // one extra bit so a full fifo can be told apart from an empty one
  localparam int fifoCountW = $clog2(fifoDepth + 1);

  // apb requester side
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } ApbReq;

  // apb completer side, prdata not read by the logger
  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } ApbRsp;

endpackage

`default_nettype wire

/* rtl/sectorLogTop.sv */
// top level: UART receiver, byte FIFO and sector writer
`timescale 1ns/1ps
`default_nettype none

module sectorLogTop (
  input  logic                clk,
  input  logic                rstn,
  input  logic                rx,
  output sectorLogPkg::ApbReq apbReq,
  input  sectorLogPkg::ApbRsp apbRsp,
  output logic                overflow,
  output logic                error
);

  // receiver to fifo
  logic [7:0] rxByte;
  logic rxValid;
  // fifo to writer
  logic [7:0] headByte;
  logic notEmpty;
  logic pop;

  uartByteRx rxInst (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .rxByte  (rxByte),
    .rxValid (rxValid)
  );

  byteFifo fifoInst (
    .clk      (clk),
    .rstn     (rstn),
    .push     (rxValid),
    .pushByte (rxByte),
    .pop      (pop),
    .headByte (headByte),
    .notEmpty (notEmpty),
    .overflow (overflow)
  );

  sectorWriter writerInst (
    .clk      (clk),
    .rstn     (rstn),
    .headByte (headByte),
    .notEmpty (notEmpty),
    .pop      (pop),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .error    (error)
  );

endmodule

`default_nettype wire

/* rtl/sectorWriter.sv */
// sector writer: packs bytes into words, APB writes of sectors and length records, halt on error
`timescale 1ns/1ps
`default_nettype none

module sectorWriter (
  input  logic                clk,
  input  logic                rstn,
  input  logic [7:0]          headByte,
  input  logic                notEmpty,
  output logic                pop,
  output sectorLogPkg::ApbReq apbReq,
  input  sectorLogPkg::ApbRsp apbRsp,
  output logic                error
);

  typedef enum logic [2:0] {
    collect,
    setup,
    access,
    lengthSetup,
    lengthAccess,
    halted
  } WrState;

  WrState state;
  // earliest byte ends up in bits 7:0
  logic [31:0] wordShift;
  logic [1:0] byteIdx;
  logic [31:0] wordAddr;
  logic [sectorLogPkg::wordIdxW-1:0] wordIdx;
  logic [sectorLogPkg::sectorCntW-1:0] sectorsDone;
  logic [sectorLogPkg::sectorCntW-1:0] nextSectors;
  // length record owed, gives one idle bus cycle before its setup
  logic lengthPending;
  logic lastWord;
  logic [31:0] lengthWord;

  assign nextSectors = sectorsDone + 1'b1;
  assign lastWord = (wordIdx == sectorLogPkg::wordIdxW'(sectorLogPkg::wordsPerSector - 1));
  // running byte total, whole sectors only
  assign lengthWord = 32'(sectorsDone) * 32'(sectorLogPkg::sectorBytes);

  // one byte per cycle while gathering, none while a record is owed
  assign pop = (state == collect) && notEmpty && !lengthPending;
  assign error = (state == halted);

  // ------------------------------
  // apb request
  // ------------------------------
  always_comb begin
    apbReq.psel    = (state == setup) || (state == access) ||
                     (state == lengthSetup) || (state == lengthAccess);
    apbReq.penable = (state == access) || (state == lengthAccess);
    // logger never reads
    apbReq.pwrite  = 1'b1;
    if (state == lengthSetup || state == lengthAccess) begin
      apbReq.paddr  = sectorLogPkg::lengthAddr;
      apbReq.pwdata = lengthWord;
    end else begin
      apbReq.paddr  = wordAddr;
      apbReq.pwdata = wordShift;
    end
  end

  // ------------------------------
  // main FSM
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state         <= collect;
      byteIdx       <= '0;
      wordAddr      <= sectorLogPkg::dataBase;
      wordIdx       <= '0;
      sectorsDone   <= '0;
      lengthPending <= 1'b0;
    end else begin
      case (state)
        collect: begin
          if (lengthPending) begin
            // bus was idle for this cycle, start the record now
            lengthPending <= 1'b0;
            state         <= lengthSetup;
          end else if (notEmpty) begin
            byteIdx <= byteIdx + 1'b1;
            if (byteIdx == 2'd3) begin
              state <= setup;
            end
          end
        end
        setup: state <= access;
        access: begin
          if (apbRsp.pready) begin
            if (apbRsp.pslverr) begin
              state <= halted;
            end else begin
              wordAddr <= wordAddr + 32'(sectorLogPkg::wordBytes);
              state    <= collect;
              if (lastWord) begin
                wordIdx     <= '0;
                sectorsDone <= nextSectors;
                // record first, the limit check waits for it
                if ((nextSectors % sectorLogPkg::sectorCntW'(sectorLogPkg::updateEvery)) == '0) begin
                  lengthPending <= 1'b1;
                end else if (nextSectors == sectorLogPkg::sectorCntW'(sectorLogPkg::maxSectors)) begin
                  state <= halted;
                end
              end else begin
                wordIdx <= wordIdx + 1'b1;
              end
            end
          end
        end
        lengthSetup: state <= lengthAccess;
        lengthAccess: begin
          if (apbRsp.pready) begin
            if (apbRsp.pslverr ||
                sectorsDone == sectorLogPkg::sectorCntW'(sectorLogPkg::maxSectors)) begin
              state <= halted;
            end else begin
              state <= collect;
            end
          end
        end
        // stays here until reset
        halted: state <= halted;
        default: state <= halted;
      endcase
    end
  end

  // byte packing, payload only
  always_ff @(posedge clk) begin
    if (pop) begin
      wordShift <= {headByte, wordShift[31:8]};
    end
  end

  // ------------------------------
  // apb protocol checks
  // ------------------------------
  enableNeedsSel: assert property (@(posedge clk) disable iff (!rstn)
    apbReq.penable |-> apbReq.psel);

  // address and data hold across wait states
  stableWhileWaiting: assert property (@(posedge clk) disable iff (!rstn)
    apbReq.penable && !apbRsp.pready |=> $stable(apbReq.paddr) && $stable(apbReq.pwdata));

endmodule

`default_nettype wire

/* rtl/uartByteRx.sv */
// UART receiver: line synchronizer, start detect, mid-bit sampling, stop check
`timescale 1ns/1ps
`default_nettype none

module uartByteRx (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rx,
  output logic [7:0] rxByte,
  output logic       rxValid
);

  typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} RxState;

  RxState state;
  // two flop synchronizer, idle line is high
  logic rxMeta;
  logic rxSync;
  // cycles left until the next sample point
  logic [sectorLogPkg::bitTickW-1:0] tickCnt;
  logic [2:0] bitIdx;
  logic [7:0] dataShift;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  // ------------------------------
  // frame FSM
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= rxIdle;
      tickCnt <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
    end else begin
      // strobe lasts one cycle only
      rxValid <= 1'b0;
      case (state)
        rxIdle: begin
          // falling edge of start bit, wait half a bit to reach its middle
          if (!rxSync) begin
            state   <= rxStart;
            tickCnt <= sectorLogPkg::bitTickW'(sectorLogPkg::bitCycles / 2 - 1);
          end
        end
        rxStart: begin
          if (tickCnt == '0) begin
            // glitch filter, start must still be low mid-bit
            if (!rxSync) begin
              state   <= rxData;
              tickCnt <= sectorLogPkg::bitTickW'(sectorLogPkg::bitCycles - 1);
              bitIdx  <= '0;
            end else begin
              state <= rxIdle;
            end
          end else begin
            tickCnt <= tickCnt - 1'b1;
          end
        end
        rxData: begin
          if (tickCnt == '0) begin
            tickCnt <= sectorLogPkg::bitTickW'(sectorLogPkg::bitCycles - 1);
            if (bitIdx == 3'd7) begin
              state <= rxStop;
            end else begin
              bitIdx <= bitIdx + 1'b1;
            end
          end else begin
            tickCnt <= tickCnt - 1'b1;
          end
        end
        rxStop: begin
          if (tickCnt == '0) begin
            // bad stop bit drops the frame
            rxValid <= rxSync;
            state   <= rxIdle;
          end else begin
            tickCnt <= tickCnt - 1'b1;
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

  // lsb first on the line, so shift in from the top
  always_ff @(posedge clk) begin
    if (state == rxData && tickCnt == '0) begin
      dataShift <= {rxSync, dataShift[7:1]};
    end
  end

  assign rxByte = dataShift;

endmodule

`default_nettype wire

/* testbench/tbSectorLog.sv */
// testbench for the sector logger: clock, reset, LFSR, UART driver, APB store model, checks, tests
`timescale 1ns/1ps
`default_nettype none

module tbSectorLog;

  localparam int idleCycles = 200;
  localparam int drainLimit = 5000;
  localparam int quietWindow = 300;

  logic clk;
  logic rstn;
  logic rx;
  logic overflow;
  logic error;
  sectorLogPkg::ApbReq apbReq;
  sectorLogPkg::ApbRsp apbRsp = '0;

  // galois LFSR, one step per random bit
  logic [15:0] lfsr = 16'd8153;
  // reference model and store
  logic [7:0] byteQ [$];
  logic [31:0] mem [logic [31:0]];
  logic [31:0] logAddr [$];
  logic [31:0] logData [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  // store model knobs and state
  logic holdReady = 1'b0;
  logic failNext = 1'b0;
  logic waiting = 1'b0;
  int waitLeft = 0;
  int stallCycles = 0;
  int pselCount = 0;
  logic [31:0] lastAddr;
  logic [31:0] lastData;
  // bookkeeping
  string testName = "init";
  int errCount = 0;
  int testErrStart = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  sectorLogTop UUT (
    .clk      (clk),
    .rstn     (rstn),
    .rx       (rx),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .overflow (overflow),
    .error    (error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] randBits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
    return v;
  endfunction

  task automatic checkVal(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errCount++;
      $display("Fail %s: %s expected %h actual %h", testName, what, exp, act);
    end
  endtask

  task automatic reportProblem(input string msg);
    errCount++;
    $display("%s: %s", testName, msg);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testErrStart = errCount;
  endtask

  task automatic endTest();
    if (errCount == testErrStart) begin
      testsPassed++;
      $display("test %s finished: ok", testName);
    end else begin
      testsFailed++;
      $display("test %s finished: %0d errors", testName, errCount - testErrStart);
    end
  endtask

  // model is cleared one cycle into reset, bus already idle then
  task automatic applyReset();
    @(negedge clk);
    rstn = 1'b0;
    @(negedge clk);
    byteQ.delete();
    mem.delete();
    logAddr.delete();
    logData.delete();
    holdReady = 1'b0;
    failNext = 1'b0;
    repeat (2) @(negedge clk);
    rstn = 1'b1;
  endtask

  // lsb first, one bit per bitCycles clocks
  task automatic sendByte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rx = frame[i];
      repeat (sectorLogPkg::bitCycles - 1) @(negedge clk);
    end
  endtask

  task automatic sendRandom(input int count);
    logic [7:0] b;
    for (int i = 0; i < count; i++) begin
      b = randBits(8);
      byteQ.push_back(b);
      sendByte(b);
    end
  endtask

  // expected write sequence, record after every second full sector
  task automatic buildExpected();
    int words;
    expAddr.delete();
    expData.delete();
    words = byteQ.size() / 4;
    for (int n = 0; n < words; n++) begin
      expAddr.push_back(sectorLogPkg::dataBase + 32'(4 * n));
      expData.push_back({byteQ[4*n+3], byteQ[4*n+2], byteQ[4*n+1], byteQ[4*n]});
      if ((n + 1) % 128 == 0 && ((n + 1) / 128) % 2 == 0) begin
        expAddr.push_back(sectorLogPkg::lengthAddr);
        expData.push_back(32'((n + 1) / 128 * 512));
      end
    end
  endtask

  task automatic waitLog(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (logAddr.size() < target && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (logAddr.size() < target) begin
      reportProblem($sformatf("timed out waiting for %0d bus writes", target));
    end
  endtask

  task automatic waitFlag(input logic useError, input int limit);
    int cycles;
    cycles = 0;
    while (!(useError ? error : overflow) && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!(useError ? error : overflow)) begin
      reportProblem(useError ? "error never went high" : "overflow never went high");
    end
  endtask

  task automatic compareMem();
    for (int i = 0; i < expAddr.size(); i++) begin
      if (expAddr[i] != sectorLogPkg::lengthAddr) begin
        if (!mem.exists(expAddr[i])) begin
          reportProblem($sformatf("no write seen at address %h", expAddr[i]));
        end else begin
          checkVal($sformatf("word at %h", expAddr[i]), expData[i], mem[expAddr[i]]);
        end
      end
    end
  endtask

  task automatic compareLog();
    int n;
    checkVal("write count", expAddr.size(), logAddr.size());
    n = (expAddr.size() < logAddr.size()) ? expAddr.size() : logAddr.size();
    for (int i = 0; i < n; i++) begin
      checkVal($sformatf("address of write %0d", i), expAddr[i], logAddr[i]);
      checkVal($sformatf("data of write %0d", i), expData[i], logData[i]);
    end
  endtask

  // ------------------------------
  // APB store model
  // ------------------------------
  always @(negedge clk) begin
    if (!rstn) begin
      apbRsp.pready = 1'b0;
      apbRsp.pslverr = 1'b0;
      waiting = 1'b0;
    end else if (apbReq.psel && !apbReq.penable) begin
      // setup phase, pick 0 to 3 wait states
      waitLeft = int'(randBits(2));
      pselCount++;
      apbRsp.pready = 1'b0;
      apbRsp.pslverr = 1'b0;
      waiting = 1'b0;
    end else if (apbReq.psel && apbReq.penable) begin
      if (waiting) begin
        checkVal("paddr held in wait", lastAddr, apbReq.paddr);
        checkVal("pwdata held in wait", lastData, apbReq.pwdata);
      end
      if (holdReady || waitLeft != 0) begin
        if (waitLeft != 0) begin
          waitLeft--;
        end
        stallCycles++;
        apbRsp.pready = 1'b0;
        waiting = 1'b1;
        lastAddr = apbReq.paddr;
        lastData = apbReq.pwdata;
      end else begin
        apbRsp.pready = 1'b1;
        waiting = 1'b0;
        checkVal("pwrite", 32'd1, 32'(apbReq.pwrite));
        if (failNext && apbReq.paddr != sectorLogPkg::lengthAddr) begin
          // slave error, write not stored
          apbRsp.pslverr = 1'b1;
          failNext = 1'b0;
        end else begin
          mem[apbReq.paddr] = apbReq.pwdata;
          logAddr.push_back(apbReq.paddr);
          logData.push_back(apbReq.pwdata);
        end
      end
    end else begin
      apbRsp.pready = 1'b0;
      apbRsp.pslverr = 1'b0;
      waiting = 1'b0;
    end
  end

  // ------------------------------
  // tests
  // ------------------------------
  initial begin
    int seenBusy;
    int pselBefore;
    rstn = 1'b0;
    rx = 1'b1;
    applyReset();

    beginTest("reset idle");
    seenBusy = 0;
    repeat (idleCycles) begin
      @(negedge clk);
      if (apbReq.psel || apbReq.penable || error || overflow) begin
        seenBusy++;
      end
    end
    checkVal("busy cycles on idle line", 32'd0, 32'(seenBusy));
    endTest();

    beginTest("data words");
    sendRandom(2048);
    buildExpected();
    waitLog(expAddr.size(), drainLimit);
    compareMem();
    endTest();

    // bytes keep going, sectors 5 to 8
    beginTest("length records");
    sendRandom(2048);
    buildExpected();
    waitLog(expAddr.size(), drainLimit);
    compareLog();
    endTest();

    beginTest("wait state hold");
    stallCycles = 0;
    sendRandom(256);
    buildExpected();
    waitLog(expAddr.size(), drainLimit);
    compareLog();
    checkVal("wait states seen", 32'd1, 32'(stallCycles != 0));
    endTest();

    // writer stuck in access, fifo fills up
    beginTest("overflow");
    holdReady = 1'b1;
    sendRandom(sectorLogPkg::fifoDepth + 8);
    waitFlag(1'b0, drainLimit);
    checkVal("overflow while stalled", 32'd1, 32'(overflow));
    applyReset();
    checkVal("overflow after reset", 32'd0, 32'(overflow));
    endTest();

    beginTest("slave error");
    failNext = 1'b1;
    sendRandom(8);
    waitFlag(1'b1, drainLimit);
    pselBefore = pselCount;
    sendRandom(8);
    repeat (quietWindow) @(negedge clk);
    checkVal("setup phases after error", 32'(pselBefore), 32'(pselCount));
    checkVal("error held", 32'd1, 32'(error));
    endTest();

    // full file, halt after the last length record
    beginTest("file limit");
    applyReset();
    sendRandom(sectorLogPkg::maxSectors * sectorLogPkg::sectorBytes);
    waitFlag(1'b1, drainLimit);
    buildExpected();
    compareLog();
    endTest();

    $display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
    if (errCount == 0 && testsFailed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/sectorLogPkg.sv
rtl/uartByteRx.sv
rtl/byteFifo.sv
rtl/sectorWriter.sv
rtl/sectorLogTop.sv
testbench/tbSectorLog.sv
